/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_axi_perf_mon
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Everything OK

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
hw/axi_perf_pkg.sv
hw/axi_event_tap.sv
hw/perf_counter_bank.sv
hw/perf_ctrl.sv
hw/axi_perf_mon.sv
verification/axi_perf_mon_props.sv
verification/tb_axi_perf_mon.sv

/* hw/axi_event_tap.sv */
module axi_event_tap (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  axi_perf_pkg::axi_req_t axi_req_i,
    input  axi_perf_pkg::axi_rsp_t axi_rsp_i,
    output axi_perf_pkg::axi_req_t axi_req_o,
    output axi_perf_pkg::axi_rsp_t axi_rsp_o,
    output axi_perf_pkg::evt_vec_t evt_o
);
    import axi_perf_pkg::*;

    evt_vec_t evt_d;
    evt_vec_t evt_q;

    // Bus passes straight through, no added latency
    assign axi_req_o = axi_req_i;
    assign axi_rsp_o = axi_rsp_i;

    //////////////////////////////
    // Event classification
    //////////////////////////////

    always_comb begin
        evt_d              = '0;
        // Completed handshakes
        evt_d[EVT_R_BEAT]  = axi_rsp_i.r_valid & axi_req_i.r_ready;
        evt_d[EVT_B_RESP]  = axi_rsp_i.b_valid & axi_req_i.b_ready;
        // Valid held back by the master
        evt_d[EVT_R_STALL] = axi_rsp_i.r_valid & ~axi_req_i.r_ready;
        evt_d[EVT_B_STALL] = axi_rsp_i.b_valid & ~axi_req_i.b_ready;
    end

    // Register stage keeps bus timing away from the counters
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            evt_q <= '0;
        end else begin
            evt_q <= evt_d;
        end
    end

    assign evt_o = evt_q;

endmodule

/* hw/axi_perf_mon.sv */
module axi_perf_mon (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  axi_perf_pkg::axi_req_t axi_req_i,
    input  axi_perf_pkg::axi_rsp_t axi_rsp_i,
    output axi_perf_pkg::axi_req_t axi_req_o,
    output axi_perf_pkg::axi_rsp_t axi_rsp_o,
    input  axi_perf_pkg::cmd_t     cmd_i,
    input  logic                   cmd_req_i,
    output axi_perf_pkg::reply_t   reply_o,
    output logic                   cmd_ack_o
);
    import axi_perf_pkg::*;

    evt_vec_t         evt;
    logic             count_en;
    logic             clr_one;
    logic             clr_all;
    event_e           rd_sel;
    logic [CNT_W-1:0] rd_data;

    //////////////////////////////
    // Bus tap
    //////////////////////////////

    axi_event_tap u_tap (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .axi_req_i (axi_req_i),
        .axi_rsp_i (axi_rsp_i),
        .axi_req_o (axi_req_o),
        .axi_rsp_o (axi_rsp_o),
        .evt_o     (evt)
    );

    //////////////////////////////
    // Host command control
    //////////////////////////////

    perf_ctrl u_ctrl (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .cmd_i      (cmd_i),
        .cmd_req_i  (cmd_req_i),
        .reply_o    (reply_o),
        .cmd_ack_o  (cmd_ack_o),
        .count_en_o (count_en),
        .clr_one_o  (clr_one),
        .clr_all_o  (clr_all),
        .sel_o      (rd_sel),
        .rd_data_i  (rd_data)
    );

    // Event counters
    perf_counter_bank u_cnt (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .evt_i      (evt),
        .count_en_i (count_en),
        .clr_one_i  (clr_one),
        .clr_all_i  (clr_all),
        .sel_i      (rd_sel),
        .rd_data_o  (rd_data)
    );

endmodule

/* hw/axi_perf_pkg.sv */
package axi_perf_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int unsigned CNT_W   = 32;
    localparam int unsigned NUM_EVT = 4;

    // Saturation value of every counter
    localparam logic [CNT_W-1:0] CNT_MAX = {CNT_W{1'b1}};

    //////////////////////////////
    // AXI response-side signals
    //////////////////////////////

    // Ready signals driven by the master
    typedef struct packed {
        logic r_ready;
        logic b_ready;
    } axi_req_t;

    // Valid signals driven by the slave
    typedef struct packed {
        logic r_valid;
        logic b_valid;
    } axi_rsp_t;

    //////////////////////////////
    // Events and commands
    //////////////////////////////

    // Also the index into the event vector and the counter bank
    typedef enum logic [1:0] {
        EVT_R_BEAT  = 2'd0,
        EVT_B_RESP  = 2'd1,
        EVT_R_STALL = 2'd2,
        EVT_B_STALL = 2'd3
    } event_e;

    typedef logic [NUM_EVT-1:0] evt_vec_t;

    typedef enum logic [2:0] {
        OP_START     = 3'd0,
        OP_STOP      = 3'd1,
        OP_READ      = 3'd2,
        OP_CLEAR     = 3'd3,
        OP_CLEAR_ALL = 3'd4
    } cmd_op_e;

    typedef struct packed {
        cmd_op_e op;
        event_e  sel;
    } cmd_t;

    typedef struct packed {
        logic [CNT_W-1:0] data;
        logic             running; // enable state after the command
    } reply_t;

endpackage

/* hw/perf_counter_bank.sv */
module perf_counter_bank (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  axi_perf_pkg::evt_vec_t             evt_i,
    input  logic                               count_en_i,
    input  logic                               clr_one_i,
    input  logic                               clr_all_i,
    input  axi_perf_pkg::event_e               sel_i,
    output logic [axi_perf_pkg::CNT_W-1:0]     rd_data_o
);
    import axi_perf_pkg::*;

    logic [CNT_W-1:0] cnt_q [NUM_EVT];
    logic [CNT_W-1:0] cnt_d [NUM_EVT];

    //////////////////////////////
    // Counters
    //////////////////////////////

    for (genvar i = 0; i < NUM_EVT; i++) begin : g_cnt
        logic clr;
        logic inc;

        assign clr = clr_all_i | (clr_one_i && (sel_i == event_e'(i)));
        assign inc = evt_i[i] & count_en_i;

        // Clear beats a coincident increment
        always_comb begin
            cnt_d[i] = cnt_q[i];
            if (clr) begin
                cnt_d[i] = '0;
            end else if (inc && (cnt_q[i] != CNT_MAX)) begin
                cnt_d[i] = cnt_q[i] + 1'b1;
            end
        end

        always_ff @(posedge clk_i) begin
            if (!rst_ni) begin
                cnt_q[i] <= '0;
            end else begin
                cnt_q[i] <= cnt_d[i];
            end
        end
    end

    // Read port
    assign rd_data_o = cnt_q[sel_i];

endmodule

/* hw/perf_ctrl.sv */
module perf_ctrl (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  axi_perf_pkg::cmd_t             cmd_i,
    input  logic                           cmd_req_i,
    output axi_perf_pkg::reply_t           reply_o,
    output logic                           cmd_ack_o,
    output logic                           count_en_o,
    output logic                           clr_one_o,
    output logic                           clr_all_o,
    output axi_perf_pkg::event_e           sel_o,
    input  logic [axi_perf_pkg::CNT_W-1:0] rd_data_i
);
    import axi_perf_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_LOW
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   en_q;
    event_e sel_q;
    reply_t reply_q;
    logic   take_cmd;

    // A request is accepted only from IDLE
    assign take_cmd = (state_q == IDLE) && cmd_req_i;

    // One-cycle clear pulses, applied on the accepting edge
    assign clr_one_o = take_cmd && (cmd_i.op == OP_CLEAR);
    assign clr_all_o = take_cmd && (cmd_i.op == OP_CLEAR_ALL);

    // Selected counter stays pinned until the reply is captured
    assign sel_o = (state_q == IDLE) ? cmd_i.sel : sel_q;

    //////////////////////////////
    // Handshake FSM
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (cmd_req_i) begin
                    state_d = ACK;
                end
            end
            // Reply captured here, ack goes high next
            ACK: state_d = WAIT_LOW;
            WAIT_LOW: begin
                if (!cmd_req_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            en_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (take_cmd) begin
                case (cmd_i.op)
                    OP_START: en_q <= 1'b1;
                    OP_STOP:  en_q <= 1'b0;
                    default:  en_q <= en_q;
                endcase
            end
        end
    end

    // Counter value seen here already reflects the accepting edge
    always_ff @(posedge clk_i) begin
        if (take_cmd) begin
            sel_q <= cmd_i.sel;
        end
        if (state_q == ACK) begin
            reply_q.data    <= rd_data_i;
            reply_q.running <= en_q;
        end
    end

    assign reply_o    = reply_q;
    assign cmd_ack_o  = (state_q == WAIT_LOW);
    assign count_en_o = en_q;

endmodule

/* verification/axi_perf_mon_props.sv */
module axi_perf_mon_props (
    input logic                   clk_i,
    input logic                   rst_ni,
    input axi_perf_pkg::axi_req_t req_in_i,
    input axi_perf_pkg::axi_rsp_t rsp_in_i,
    input axi_perf_pkg::axi_req_t req_out_i,
    input axi_perf_pkg::axi_rsp_t rsp_out_i,
    input logic                   cmd_req_i,
    input logic                   cmd_ack_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Ack may only rise in answer to a pending request
    ack_rise_on_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(cmd_ack_i) |-> $past(cmd_req_i))
        else $error("cmd_ack_o rose without cmd_req_i high");

    // Ack drops only once the host has released the request
    ack_fall_after_release: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $fell(cmd_ack_i) |-> $past(!cmd_req_i))
        else $error("cmd_ack_o fell while cmd_req_i was still high");

    // Zero-latency pass-through
    bus_pass_through: assert property (@(posedge clk_i)
        (req_out_i == req_in_i) && (rsp_out_i == rsp_in_i))
        else $error("AXI pass-through outputs differ from inputs");

endmodule

bind axi_perf_mon axi_perf_mon_props u_props (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_in_i  (axi_req_i),
    .rsp_in_i  (axi_rsp_i),
    .req_out_i (axi_req_o),
    .rsp_out_i (axi_rsp_o),
    .cmd_req_i (cmd_req_i),
    .cmd_ack_i (cmd_ack_o)
);

/* verification/axi_perf_trace.txt */
# Bus line:     B r_valid r_ready b_valid b_ready cycles
# Command line: C test_name op sel expected_data expected_running
B 0 0 0 0 3
C reset_r_beat     READ R_BEAT  0 0
C reset_b_resp     READ B_RESP  0 0
C reset_r_stall    READ R_STALL 0 0
C reset_b_stall    READ B_STALL 0 0
# Traffic while stopped
B 1 1 1 0 3
B 1 0 1 1 2
B 0 0 0 0 2
C stopped_r_beat   READ R_BEAT  0 0
C stopped_b_resp   READ B_RESP  0 0
C stopped_r_stall  READ R_STALL 0 0
C stopped_b_stall  READ B_STALL 0 0
# Beats after start
C start            START R_BEAT 0 1
B 1 1 0 0 5
B 1 1 1 1 3
B 0 1 1 1 2
B 0 0 0 0 2
C beat_r           READ R_BEAT  8 1
C beat_b           READ B_RESP  5 1
# Stalls
B 1 0 0 0 4
B 1 0 1 0 6
B 0 1 1 0 1
B 1 1 0 0 2
B 0 0 0 0 2
C stall_r          READ R_STALL 10 1
C stall_b          READ B_STALL 7 1
C reread_r_stall   READ R_STALL 10 1
C reread_r_beat    READ R_BEAT  10 1
C reread_b_resp    READ B_RESP  5 1
# Clearing
C clear_r_stall    CLEAR R_STALL 0 1
C keep_r_beat      READ R_BEAT  10 1
C keep_b_stall     READ B_STALL 7 1
B 1 0 1 1 3
B 0 0 0 0 2
C recount_r_stall  READ R_STALL 3 1
C clear_all        CLEAR_ALL B_RESP 0 1
C cleared_r_beat   READ R_BEAT  0 1
C cleared_b_stall  READ B_STALL 0 1
B 1 1 1 0 4
B 0 0 0 0 2
# Stop freezes the counters
C stop             STOP R_BEAT 4 0
B 1 1 1 1 6
B 1 0 1 0 5
B 0 0 0 0 2
C frozen_r_beat    READ R_BEAT  4 0
C frozen_b_stall   READ B_STALL 4 0
C frozen_b_resp    READ B_RESP  0 0
C frozen_r_stall   READ R_STALL 0 0

/* verification/tb_axi_perf_mon.sv */
module tb_axi_perf_mon;
    timeunit 1ns;
    timeprecision 1ps;

    import axi_perf_pkg::*;

    localparam string TRACE_FILE      = "verification/axi_perf_trace.txt";
    localparam int    CYCLES_PER_LINE = 20;
    localparam int    CYCLE_MARGIN    = 100;

    logic     clk_i = 1'b0;
    logic     rst_ni;
    axi_req_t axi_req;
    axi_rsp_t axi_rsp;
    axi_req_t axi_req_out;
    axi_rsp_t axi_rsp_out;
    cmd_t     cmd;
    logic     cmd_req;
    reply_t   reply;
    logic     cmd_ack;

    // Reference tally built from the bus lines of the trace
    int unsigned tally [NUM_EVT];
    logic        model_running;

    int    pass_cnt    = 0;
    int    fail_cnt    = 0;
    int    cycle_cnt   = 0;
    int    cycle_limit = 0;
    logic  in_handshake = 1'b0;
    string cur_test     = "";

    always #5 clk_i = ~clk_i;

    axi_perf_mon u_axi_perf_mon (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .axi_req_i (axi_req),
        .axi_rsp_i (axi_rsp),
        .axi_req_o (axi_req_out),
        .axi_rsp_o (axi_rsp_out),
        .cmd_i     (cmd),
        .cmd_req_i (cmd_req),
        .reply_o   (reply),
        .cmd_ack_o (cmd_ack)
    );

    //////////////////////////////
    // Run limit
    //////////////////////////////

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            if (in_handshake) begin
                $display("Timeout: handshake for %s never completed", cur_test);
            end else begin
                $display("Timeout: trace did not finish within %0d cycles", cycle_limit);
            end
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic decode_op(input string s, output cmd_op_e op);
        logic known;
        known = 1'b1;
        op    = OP_READ;
        case (s)
            "START":     op = OP_START;
            "STOP":      op = OP_STOP;
            "READ":      op = OP_READ;
            "CLEAR":     op = OP_CLEAR;
            "CLEAR_ALL": op = OP_CLEAR_ALL;
            default:     known = 1'b0;
        endcase
        return known;
    endfunction

    function automatic logic decode_sel(input string s, output event_e sel);
        logic known;
        known = 1'b1;
        sel   = EVT_R_BEAT;
        case (s)
            "R_BEAT":  sel = EVT_R_BEAT;
            "B_RESP":  sel = EVT_B_RESP;
            "R_STALL": sel = EVT_R_STALL;
            "B_STALL": sel = EVT_B_STALL;
            default:   known = 1'b0;
        endcase
        return known;
    endfunction

    // Holds one bus pattern for reps cycles, tallying events while running
    task automatic apply_bus(input int rv, input int rr, input int bv, input int br,
                             input int reps);
        axi_req_t exp_req;
        axi_rsp_t exp_rsp;
        logic     mismatch;
        exp_rsp.r_valid = rv[0];
        exp_req.r_ready = rr[0];
        exp_rsp.b_valid = bv[0];
        exp_req.b_ready = br[0];
        mismatch        = 1'b0;
        axi_rsp.r_valid = rv[0];
        axi_req.r_ready = rr[0];
        axi_rsp.b_valid = bv[0];
        axi_req.b_ready = br[0];
        if (model_running) begin
            if (rv[0] && rr[0]) tally[EVT_R_BEAT] += reps;
            if (bv[0] && br[0]) tally[EVT_B_RESP] += reps;
            if (rv[0] && !rr[0]) tally[EVT_R_STALL] += reps;
            if (bv[0] && !br[0]) tally[EVT_B_STALL] += reps;
        end
        repeat (reps) begin
            // Pass-through outputs have settled since the falling edge
            @(posedge clk_i);
            if (!mismatch && (axi_req_out != exp_req || axi_rsp_out != exp_rsp)) begin
                $display("FAILED pass_through: expected req %b rsp %b, actual req %b rsp %b",
                         exp_req, exp_rsp, axi_req_out, axi_rsp_out);
                fail_cnt++;
                mismatch = 1'b1;
            end
            @(negedge clk_i);
        end
    endtask

    // Model effect of a command, applied before the reply is formed
    task automatic update_model(input cmd_op_e op, input event_e sel);
        case (op)
            OP_START:     model_running = 1'b1;
            OP_STOP:      model_running = 1'b0;
            OP_CLEAR:     tally[sel] = 0;
            OP_CLEAR_ALL: begin
                for (int i = 0; i < NUM_EVT; i++) begin
                    tally[i] = 0;
                end
            end
            default: ;
        endcase
    endtask

    //////////////////////////////
    // Host handshake
    //////////////////////////////

    task automatic run_command(input string name, input cmd_op_e op, input event_e sel,
                               output reply_t got);
        cur_test     = name;
        in_handshake = 1'b1;
        cmd.op       = op;
        cmd.sel      = sel;
        cmd_req      = 1'b1;
        @(negedge clk_i);
        while (!cmd_ack) begin
            @(negedge clk_i);
        end
        got     = reply;
        cmd_req = 1'b0;
        @(negedge clk_i);
        while (cmd_ack) begin
            @(negedge clk_i);
        end
        in_handshake = 1'b0;
    endtask

    task automatic check_command(input string name, input string op_s, input string sel_s,
                                 input logic [CNT_W-1:0] exp_data, input int exp_run);
        cmd_op_e          op;
        event_e           sel;
        reply_t           got;
        logic [CNT_W-1:0] tally_val;
        logic             ok;
        ok = decode_op(op_s, op) && decode_sel(sel_s, sel);
        if (!ok) begin
            $display("Test %s has an unknown opcode or counter name", name);
            fail_cnt++;
        end else begin
            update_model(op, sel);
            tally_val = tally[sel];
            run_command(name, op, sel, got);
            if (tally_val != exp_data || model_running != exp_run[0]) begin
                $display("Test %s: trace expects %0d/%0d but bus tally gives %0d/%0d",
                         name, exp_data, exp_run, tally_val, model_running);
                fail_cnt++;
            end else if (got.data != exp_data || got.running != exp_run[0]) begin
                $display("FAILED %s: expected data %0d running %0b, actual data %0d running %0b",
                         name, exp_data, exp_run[0], got.data, got.running);
                fail_cnt++;
            end else begin
                $display("ok     %s", name);
                pass_cnt++;
            end
        end
    endtask

    task automatic run_trace(input int fd);
        string            tok;
        string            rest;
        string            name;
        string            op_s;
        string            sel_s;
        int               code;
        int               rv, rr, bv, br, reps;
        int               exp_run;
        logic [CNT_W-1:0] exp_data;
        logic             done;
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1'b1;
            end else if (tok[0] == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "B") begin
                code = $fscanf(fd, "%d %d %d %d %d", rv, rr, bv, br, reps);
                if (code != 5) begin
                    $display("Malformed bus line in the trace");
                    fail_cnt++;
                    done = 1'b1;
                end else begin
                    apply_bus(rv, rr, bv, br, reps);
                end
            end else if (tok == "C") begin
                code = $fscanf(fd, "%s %s %s %d %d", name, op_s, sel_s, exp_data, exp_run);
                if (code != 5) begin
                    $display("Malformed command line in the trace");
                    fail_cnt++;
                    done = 1'b1;
                end else begin
                    check_command(name, op_s, sel_s, exp_data, exp_run);
                end
            end else begin
                $display("Unknown line kind %s in the trace", tok);
                fail_cnt++;
            end
        end
    endtask

    initial begin
        int    fd;
        int    n_lines;
        string line;
        rst_ni        = 1'b0;
        axi_req       = '0;
        axi_rsp       = '0;
        cmd           = '0;
        cmd_req       = 1'b0;
        model_running = 1'b0;
        for (int i = 0; i < NUM_EVT; i++) begin
            tally[i] = 0;
        end

        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open trace file %s", TRACE_FILE);
            fail_cnt++;
        end else begin
            // Run limit scales with the trace length
            n_lines = 0;
            while ($fgets(line, fd) != 0) begin
                n_lines++;
            end
            $fclose(fd);
            cycle_limit = CYCLES_PER_LINE * n_lines + CYCLE_MARGIN;

            repeat (5) @(posedge clk_i);
            @(negedge clk_i);
            rst_ni = 1'b1;

            fd = $fopen(TRACE_FILE, "r");
            run_trace(fd);
            $fclose(fd);
        end

        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
